/* common/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    ////////////////////
    // Field types

    typedef logic [31:0] xlen_t;       // Data and address word
    typedef logic [31:0] insn_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  funct7_t;

    ////////////////////
    // Opcodes of the checked subset

    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        add_sub = 3'b000,
        sll     = 3'b001,
        slt     = 3'b010,
        sltu    = 3'b011,
        xor_op  = 3'b100,
        srl_sra = 3'b101,
        or_op   = 3'b110,
        and_op  = 3'b111
    } alu_funct3_e;

    ////////////////////
    // funct7 encodings

    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;   // SUB and SRA

endpackage

`default_nettype wire

/* common/check_pkg.sv */
`default_nettype none

package check_pkg;

    localparam int COUNT_WIDTH_DEFAULT = 16;

    typedef logic [COUNT_WIDTH_DEFAULT-1:0] count_t;

    // Causes listed in reporting priority
    typedef enum logic [2:0] {
        cause_none     = 3'd0,
        cause_illegal  = 3'd1,
        cause_rd_addr  = 3'd2,
        cause_rd_wdata = 3'd3,
        cause_pc_wdata = 3'd4
    } mismatch_cause_e;

endpackage

`default_nettype wire

/* common/retire_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface retire_if;

    logic                  valid;
    rv_isa_pkg::insn_t     insn;
    rv_isa_pkg::xlen_t     pc_rdata;
    rv_isa_pkg::xlen_t     pc_wdata;
    rv_isa_pkg::xlen_t     rs1_rdata;
    rv_isa_pkg::xlen_t     rs2_rdata;
    rv_isa_pkg::reg_addr_t rd_addr;
    rv_isa_pkg::xlen_t     rd_wdata;
    logic                  trap;

    modport producer (
        output valid, insn, pc_rdata, pc_wdata, rs1_rdata, rs2_rdata,
        output rd_addr, rd_wdata, trap
    );

    modport consumer (
        input valid, insn, pc_rdata, pc_wdata, rs1_rdata, rs2_rdata,
        input rd_addr, rd_wdata, trap
    );

endinterface

`default_nettype wire

/* verilog/retire_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_capture (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  trace_valid,
    input  rv_isa_pkg::insn_t     trace_insn,
    input  rv_isa_pkg::xlen_t     trace_pc_rdata,
    input  rv_isa_pkg::xlen_t     trace_pc_wdata,
    input  rv_isa_pkg::xlen_t     trace_rs1_rdata,
    input  rv_isa_pkg::xlen_t     trace_rs2_rdata,
    input  rv_isa_pkg::reg_addr_t trace_rd_addr,
    input  rv_isa_pkg::xlen_t     trace_rd_wdata,
    input  logic                  trace_trap,
    retire_if.producer            trace
);

    // Retirements seen during reset are dropped
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            trace.valid <= 1'b0;
        end else begin
            trace.valid <= trace_valid;
        end
    end

    always_ff @(posedge clock) begin
        trace.insn      <= trace_insn;
        trace.pc_rdata  <= trace_pc_rdata;
        trace.pc_wdata  <= trace_pc_wdata;
        trace.rs1_rdata <= trace_rs1_rdata;
        trace.rs2_rdata <= trace_rs2_rdata;
        trace.rd_addr   <= trace_rd_addr;
        trace.rd_wdata  <= trace_rd_wdata;
        trace.trap      <= trace_trap;
    end

endmodule

`default_nettype wire

/* isa_spec/isa_spec_rv32i_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module isa_spec_rv32i_alu (
    retire_if.consumer              trace,
    output logic                    spec_valid,
    output logic                    spec_trap,
    output rv_isa_pkg::reg_addr_t   spec_rd_addr,
    output rv_isa_pkg::xlen_t       spec_rd_wdata,
    output rv_isa_pkg::xlen_t       spec_pc_wdata
);

    rv_isa_pkg::opcode_e     opcode;
    rv_isa_pkg::alu_funct3_e funct3;
    rv_isa_pkg::funct7_t     funct7;
    rv_isa_pkg::reg_addr_t   rd;
    rv_isa_pkg::xlen_t       imm_i;
    rv_isa_pkg::xlen_t       imm_u;
    rv_isa_pkg::xlen_t       op_a;
    rv_isa_pkg::xlen_t       op_b;
    logic [4:0]              shamt;
    logic                    is_op;
    logic                    is_op_imm;
    logic                    is_lui;
    logic                    alt;
    logic                    illegal;
    rv_isa_pkg::xlen_t       alu_result;
    rv_isa_pkg::xlen_t       result;

    ////////////////////
    // Decode

    assign opcode = rv_isa_pkg::opcode_e'(trace.insn[6:0]);
    assign rd     = trace.insn[11:7];
    assign funct3 = rv_isa_pkg::alu_funct3_e'(trace.insn[14:12]);
    assign funct7 = trace.insn[31:25];

    assign is_op     = (opcode == rv_isa_pkg::op);
    assign is_op_imm = (opcode == rv_isa_pkg::op_imm);
    assign is_lui    = (opcode == rv_isa_pkg::lui);

    assign imm_i = {{20{trace.insn[31]}}, trace.insn[31:20]};   // Sign-extended I-type
    assign imm_u = {trace.insn[31:12], 12'b0};

    assign op_a  = trace.rs1_rdata;
    assign op_b  = is_op ? trace.rs2_rdata : imm_i;
    assign shamt = op_b[4:0];                                   // Low five bits only
    assign alt   = (funct7 == rv_isa_pkg::FUNCT7_ALT);

    ////////////////////
    // ALU

    always_comb begin
        case (funct3)
            rv_isa_pkg::add_sub: alu_result = (is_op && alt) ? op_a - op_b : op_a + op_b;
            rv_isa_pkg::sll:     alu_result = op_a << shamt;
            rv_isa_pkg::slt:     alu_result = rv_isa_pkg::xlen_t'($signed(op_a) < $signed(op_b));
            rv_isa_pkg::sltu:    alu_result = rv_isa_pkg::xlen_t'(op_a < op_b);
            rv_isa_pkg::xor_op:  alu_result = op_a ^ op_b;
            rv_isa_pkg::srl_sra: alu_result = alt ? rv_isa_pkg::xlen_t'($signed(op_a) >>> shamt)
                                                  : op_a >> shamt;
            rv_isa_pkg::or_op:   alu_result = op_a | op_b;
            rv_isa_pkg::and_op:  alu_result = op_a & op_b;
            default:             alu_result = '0;
        endcase
    end

    assign result = is_lui ? imm_u : alu_result;

    ////////////////////
    // Legal funct7 encodings

    always_comb begin
        illegal = 1'b0;
        if (is_op) begin
            if (funct7 == rv_isa_pkg::FUNCT7_ALT) begin
                illegal = !(funct3 == rv_isa_pkg::add_sub || funct3 == rv_isa_pkg::srl_sra);
            end else begin
                illegal = (funct7 != rv_isa_pkg::FUNCT7_BASE);
            end
        end else if (is_op_imm) begin
            if (funct3 == rv_isa_pkg::sll) begin
                illegal = (funct7 != rv_isa_pkg::FUNCT7_BASE);
            end else if (funct3 == rv_isa_pkg::srl_sra) begin
                illegal = !(funct7 == rv_isa_pkg::FUNCT7_BASE || alt);
            end
        end
    end

    ////////////////////
    // Spec outputs

    assign spec_valid    = trace.valid && (is_op || is_op_imm || is_lui);
    assign spec_trap     = spec_valid && illegal;
    assign spec_rd_addr  = rd;
    assign spec_rd_wdata = (rd == '0) ? '0 : result;   // x0 always reads zero
    assign spec_pc_wdata = trace.pc_rdata + 32'd4;

endmodule

`default_nettype wire

/* verilog/retire_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_checker #(
    parameter int COUNT_WIDTH = check_pkg::COUNT_WIDTH_DEFAULT
) (
    input  logic                        clock,
    input  logic                        rst_n,
    retire_if.consumer                  trace,
    input  logic                        spec_valid,
    input  logic                        spec_trap,
    input  rv_isa_pkg::reg_addr_t       spec_rd_addr,
    input  rv_isa_pkg::xlen_t           spec_rd_wdata,
    input  rv_isa_pkg::xlen_t           spec_pc_wdata,
    output logic                        mismatch,
    output rv_isa_pkg::xlen_t           mismatch_pc,
    output check_pkg::mismatch_cause_e  mismatch_cause,
    output logic [COUNT_WIDTH-1:0]      retired_count,
    output logic [COUNT_WIDTH-1:0]      checked_count,
    output logic [COUNT_WIDTH-1:0]      mismatch_count
);

    logic                       checked;
    logic                       mismatch_d;
    check_pkg::mismatch_cause_e cause_d;

    // Trapped or out-of-subset retirements are not checked
    assign checked = trace.valid && !trace.trap && spec_valid;

    // First failing check wins
    always_comb begin
        if (spec_trap) begin
            cause_d = check_pkg::cause_illegal;
        end else if (trace.rd_addr != spec_rd_addr) begin
            cause_d = check_pkg::cause_rd_addr;
        end else if (trace.rd_wdata != spec_rd_wdata) begin
            cause_d = check_pkg::cause_rd_wdata;
        end else if (trace.pc_wdata != spec_pc_wdata) begin
            cause_d = check_pkg::cause_pc_wdata;
        end else begin
            cause_d = check_pkg::cause_none;
        end
    end

    assign mismatch_d = checked && (cause_d != check_pkg::cause_none);

    ////////////////////
    // Report and counters

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mismatch       <= 1'b0;
            mismatch_cause <= check_pkg::cause_none;
            retired_count  <= '0;
            checked_count  <= '0;
            mismatch_count <= '0;
        end else begin
            mismatch       <= mismatch_d;
            mismatch_cause <= mismatch_d ? cause_d : check_pkg::cause_none;
            if (trace.valid) begin
                retired_count <= retired_count + 1'b1;
            end
            if (checked) begin
                checked_count <= checked_count + 1'b1;
            end
            if (mismatch_d) begin
                mismatch_count <= mismatch_count + 1'b1;   // Wraps
            end
        end
    end

    // Held until the next mismatch
    always_ff @(posedge clock) begin
        if (mismatch_d) begin
            mismatch_pc <= trace.pc_rdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/rvfi_check_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rvfi_check_top #(
    parameter int COUNT_WIDTH = check_pkg::COUNT_WIDTH_DEFAULT
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        trace_valid,
    input  rv_isa_pkg::insn_t           trace_insn,
    input  rv_isa_pkg::xlen_t           trace_pc_rdata,
    input  rv_isa_pkg::xlen_t           trace_pc_wdata,
    input  rv_isa_pkg::xlen_t           trace_rs1_rdata,
    input  rv_isa_pkg::xlen_t           trace_rs2_rdata,
    input  rv_isa_pkg::reg_addr_t       trace_rd_addr,
    input  rv_isa_pkg::xlen_t           trace_rd_wdata,
    input  logic                        trace_trap,
    output logic                        mismatch,
    output rv_isa_pkg::xlen_t           mismatch_pc,
    output check_pkg::mismatch_cause_e  mismatch_cause,
    output logic [COUNT_WIDTH-1:0]      retired_count,
    output logic [COUNT_WIDTH-1:0]      checked_count,
    output logic [COUNT_WIDTH-1:0]      mismatch_count
);

    logic                  spec_valid;
    logic                  spec_trap;
    rv_isa_pkg::reg_addr_t spec_rd_addr;
    rv_isa_pkg::xlen_t     spec_rd_wdata;
    rv_isa_pkg::xlen_t     spec_pc_wdata;

    retire_if trace ();   // Registered trace

    retire_capture u_capture (
        .clock           (clock),
        .rst_n           (rst_n),
        .trace_valid     (trace_valid),
        .trace_insn      (trace_insn),
        .trace_pc_rdata  (trace_pc_rdata),
        .trace_pc_wdata  (trace_pc_wdata),
        .trace_rs1_rdata (trace_rs1_rdata),
        .trace_rs2_rdata (trace_rs2_rdata),
        .trace_rd_addr   (trace_rd_addr),
        .trace_rd_wdata  (trace_rd_wdata),
        .trace_trap      (trace_trap),
        .trace           (trace.producer)
    );

    isa_spec_rv32i_alu u_spec (
        .trace         (trace.consumer),
        .spec_valid    (spec_valid),
        .spec_trap     (spec_trap),
        .spec_rd_addr  (spec_rd_addr),
        .spec_rd_wdata (spec_rd_wdata),
        .spec_pc_wdata (spec_pc_wdata)
    );

    retire_checker #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_checker (
        .clock          (clock),
        .rst_n          (rst_n),
        .trace          (trace.consumer),
        .spec_valid     (spec_valid),
        .spec_trap      (spec_trap),
        .spec_rd_addr   (spec_rd_addr),
        .spec_rd_wdata  (spec_rd_wdata),
        .spec_pc_wdata  (spec_pc_wdata),
        .mismatch       (mismatch),
        .mismatch_pc    (mismatch_pc),
        .mismatch_cause (mismatch_cause),
        .retired_count  (retired_count),
        .checked_count  (checked_count),
        .mismatch_count (mismatch_count)
    );

endmodule

`default_nettype wire

/* verification/rvfi_check_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rvfi_check_props #(
    parameter int COUNT_WIDTH = check_pkg::COUNT_WIDTH_DEFAULT
) (
    input logic                       clock,
    input logic                       rst_n,
    input logic                       mismatch,
    input rv_isa_pkg::xlen_t          mismatch_pc,
    input check_pkg::mismatch_cause_e mismatch_cause,
    input logic [COUNT_WIDTH-1:0]     retired_count,
    input logic [COUNT_WIDTH-1:0]     checked_count,
    input logic [COUNT_WIDTH-1:0]     mismatch_count,
    input logic                       exp_mismatch,
    input rv_isa_pkg::xlen_t          exp_pc,
    input check_pkg::mismatch_cause_e exp_cause,
    input logic [COUNT_WIDTH-1:0]     exp_retired,
    input logic [COUNT_WIDTH-1:0]     exp_checked,
    input logic [COUNT_WIDTH-1:0]     exp_mismatches
);

    mismatch_a: assert property (@(posedge clock) disable iff (!rst_n)
        mismatch == exp_mismatch)
    else begin
        rvfi_check_tb.error_count = rvfi_check_tb.error_count + 1;
        $error("[FAIL] mismatch expected %h got %h", $sampled(exp_mismatch), $sampled(mismatch));
    end

    cause_a: assert property (@(posedge clock) disable iff (!rst_n)
        mismatch_cause == exp_cause)
    else begin
        rvfi_check_tb.error_count = rvfi_check_tb.error_count + 1;
        $error("[FAIL] mismatch_cause expected %h got %h",
               $sampled(exp_cause), $sampled(mismatch_cause));
    end

    // Pc holds the latest mismatch from the first one on
    pc_a: assert property (@(posedge clock) disable iff (!rst_n)
        exp_mismatches != '0 |-> mismatch_pc == exp_pc)
    else begin
        rvfi_check_tb.error_count = rvfi_check_tb.error_count + 1;
        $error("[FAIL] mismatch_pc expected %h got %h", $sampled(exp_pc), $sampled(mismatch_pc));
    end

    retired_a: assert property (@(posedge clock) disable iff (!rst_n)
        retired_count == exp_retired)
    else begin
        rvfi_check_tb.error_count = rvfi_check_tb.error_count + 1;
        $error("[FAIL] retired_count expected %h got %h",
               $sampled(exp_retired), $sampled(retired_count));
    end

    checked_a: assert property (@(posedge clock) disable iff (!rst_n)
        checked_count == exp_checked)
    else begin
        rvfi_check_tb.error_count = rvfi_check_tb.error_count + 1;
        $error("[FAIL] checked_count expected %h got %h",
               $sampled(exp_checked), $sampled(checked_count));
    end

    count_a: assert property (@(posedge clock) disable iff (!rst_n)
        mismatch_count == exp_mismatches)
    else begin
        rvfi_check_tb.error_count = rvfi_check_tb.error_count + 1;
        $error("[FAIL] mismatch_count expected %h got %h",
               $sampled(exp_mismatches), $sampled(mismatch_count));
    end

endmodule

`default_nettype wire

/* verification/rvfi_check_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvfi_check_tb;

    localparam int COUNT_WIDTH  = 16;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_DIRECTED = 7;
    localparam int NUM_RANDOM   = 300;
    localparam int TIMEOUT      = RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 50;

    typedef struct packed {
        logic                       ret;
        logic                       chk;
        logic                       mis;
        check_pkg::mismatch_cause_e cause;
        rv_isa_pkg::xlen_t          pc;
    } expect_t;

    logic                       clock;
    logic                       rst_n;
    logic                       trace_valid;
    rv_isa_pkg::insn_t          trace_insn;
    rv_isa_pkg::xlen_t          trace_pc_rdata;
    rv_isa_pkg::xlen_t          trace_pc_wdata;
    rv_isa_pkg::xlen_t          trace_rs1_rdata;
    rv_isa_pkg::xlen_t          trace_rs2_rdata;
    rv_isa_pkg::reg_addr_t      trace_rd_addr;
    rv_isa_pkg::xlen_t          trace_rd_wdata;
    logic                       trace_trap;
    logic                       mismatch;
    rv_isa_pkg::xlen_t          mismatch_pc;
    check_pkg::mismatch_cause_e mismatch_cause;
    logic [COUNT_WIDTH-1:0]     retired_count;
    logic [COUNT_WIDTH-1:0]     checked_count;
    logic [COUNT_WIDTH-1:0]     mismatch_count;

    expect_t                    stage_a = '0;          // Two-deep expected pipeline
    expect_t                    stage_b = '0;
    logic                       exp_mismatch = 1'b0;
    rv_isa_pkg::xlen_t          exp_pc = '0;
    check_pkg::mismatch_cause_e exp_cause = check_pkg::cause_none;
    logic [COUNT_WIDTH-1:0]     exp_retired = '0;
    logic [COUNT_WIDTH-1:0]     exp_checked = '0;
    logic [COUNT_WIDTH-1:0]     exp_mismatches = '0;

    int                         error_count = 0;       // Raised by the bound assertions
    int                         cycle_count = 0;
    int                         sent = 0;
    logic [31:0]                rng_state = 32'd34765;
    int                         kind_map [8] = '{0, 0, 1, 1, 2, 3, 4, 1};

    rvfi_check_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_dut (
        .clock           (clock),
        .rst_n           (rst_n),
        .trace_valid     (trace_valid),
        .trace_insn      (trace_insn),
        .trace_pc_rdata  (trace_pc_rdata),
        .trace_pc_wdata  (trace_pc_wdata),
        .trace_rs1_rdata (trace_rs1_rdata),
        .trace_rs2_rdata (trace_rs2_rdata),
        .trace_rd_addr   (trace_rd_addr),
        .trace_rd_wdata  (trace_rd_wdata),
        .trace_trap      (trace_trap),
        .mismatch        (mismatch),
        .mismatch_pc     (mismatch_pc),
        .mismatch_cause  (mismatch_cause),
        .retired_count   (retired_count),
        .checked_count   (checked_count),
        .mismatch_count  (mismatch_count)
    );

    bind rvfi_check_top rvfi_check_props #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_props (
        .clock          (clock),
        .rst_n          (rst_n),
        .mismatch       (mismatch),
        .mismatch_pc    (mismatch_pc),
        .mismatch_cause (mismatch_cause),
        .retired_count  (retired_count),
        .checked_count  (checked_count),
        .mismatch_count (mismatch_count),
        .exp_mismatch   (rvfi_check_tb.exp_mismatch),
        .exp_pc         (rvfi_check_tb.exp_pc),
        .exp_cause      (rvfi_check_tb.exp_cause),
        .exp_retired    (rvfi_check_tb.exp_retired),
        .exp_checked    (rvfi_check_tb.exp_checked),
        .exp_mismatches (rvfi_check_tb.exp_mismatches)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////
    // Reference model

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // kind 0 OP, 1 OP-IMM, 2 LUI, 3 illegal funct7, other a load
    function automatic rv_isa_pkg::insn_t make_insn(input int kind);
        logic [31:0] r;
        logic [6:0]  f7;
        r  = next_rand();
        f7 = r[30] ? 7'h20 : 7'h00;
        case (kind)
            0: return {((r[14:12] == 3'd0 || r[14:12] == 3'd5) ? f7 : 7'h00), r[24:7], 7'h33};
            1: begin
                if (r[14:12] == 3'd1)
                    return {7'h00, r[24:7], 7'h13};
                if (r[14:12] == 3'd5)
                    return {f7, r[24:7], 7'h13};
                return {r[31:7], 7'h13};
            end
            2: return {r[31:7], 7'h37};
            3: return r[0] ? {7'h01, r[24:7], 7'h33} : {7'h40, r[24:15], 3'b001, r[11:7], 7'h13};
            default: return {r[31:7], 7'h03};
        endcase
    endfunction

    function automatic rv_isa_pkg::xlen_t expect_rd(input rv_isa_pkg::insn_t insn,
                                                    input rv_isa_pkg::xlen_t a,
                                                    input rv_isa_pkg::xlen_t rs2);
        rv_isa_pkg::xlen_t b;
        rv_isa_pkg::xlen_t r;
        b = (insn[6:0] == 7'h33) ? rs2 : {{20{insn[31]}}, insn[31:20]};
        case (insn[14:12])
            3'd0: r = (insn[6:0] == 7'h33 && insn[30]) ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'd0, $signed(a) < $signed(b)};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (insn[30])
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (insn[6:0] == 7'h37)
            r = {insn[31:12], 12'd0};
        if (insn[11:7] == 5'd0)
            r = '0;                                     // x0 stays zero
        return r;
    endfunction

    function automatic logic encoding_illegal(input rv_isa_pkg::insn_t insn);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = insn[31:25];
        f3 = insn[14:12];
        if (insn[6:0] == 7'h33)
            return !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        if (insn[6:0] == 7'h13 && f3 == 3'd1)
            return f7 != 7'h00;
        if (insn[6:0] == 7'h13 && f3 == 3'd5)
            return !(f7 == 7'h00 || f7 == 7'h20);
        return 1'b0;
    endfunction

    // Bit 0 of corrupt flips rd_addr, bit 1 rd_wdata and bit 2 pc_wdata
    task automatic send(input logic valid, input rv_isa_pkg::insn_t insn, input logic trap,
                        input logic [2:0] corrupt, input logic in_reset);
        rv_isa_pkg::xlen_t rs1;
        rv_isa_pkg::xlen_t rs2;
        rv_isa_pkg::xlen_t pc;
        rv_isa_pkg::xlen_t rd_data;
        logic [6:0]        opc;
        expect_t           e;
        rs1     = next_rand();
        rs2     = next_rand();
        pc      = next_rand() & 32'hffff_fffc;
        rd_data = expect_rd(insn, rs1, rs2);
        opc     = insn[6:0];
        e.ret   = valid && !in_reset;
        e.chk   = e.ret && !trap && (opc == 7'h13 || opc == 7'h33 || opc == 7'h37);
        e.pc    = pc;
        if (!e.chk)
            e.cause = check_pkg::cause_none;
        else if (encoding_illegal(insn))
            e.cause = check_pkg::cause_illegal;
        else if (corrupt[0])
            e.cause = check_pkg::cause_rd_addr;
        else if (corrupt[1])
            e.cause = check_pkg::cause_rd_wdata;
        else if (corrupt[2])
            e.cause = check_pkg::cause_pc_wdata;
        else
            e.cause = check_pkg::cause_none;
        e.mis = (e.cause != check_pkg::cause_none);
        @(posedge clock);
        rst_n           <= !in_reset;
        trace_valid     <= valid;
        trace_insn      <= insn;
        trace_pc_rdata  <= pc;
        trace_pc_wdata  <= (pc + 32'd4) ^ (corrupt[2] ? 32'h0000_0100 : 32'h0);
        trace_rs1_rdata <= rs1;
        trace_rs2_rdata <= rs2;
        trace_rd_addr   <= insn[11:7] ^ (corrupt[0] ? 5'd1 : 5'd0);
        trace_rd_wdata  <= rd_data ^ (corrupt[1] ? (rs1 | 32'd1) : 32'd0);
        trace_trap      <= trap;
        stage_a         <= e;
        sent++;
    endtask

    // Expected outputs move with the DUT, two edges after the drive
    always @(posedge clock) begin
        stage_b      <= stage_a;
        exp_mismatch <= stage_b.mis;
        exp_cause    <= stage_b.cause;
        if (stage_b.mis) begin
            exp_pc         <= stage_b.pc;
            exp_mismatches <= exp_mismatches + 1'b1;
        end
        if (stage_b.ret)
            exp_retired <= exp_retired + 1'b1;
        if (stage_b.chk)
            exp_checked <= exp_checked + 1'b1;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: stimulus did not complete within %0d cycles", TIMEOUT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////
    // Stimulus

    initial begin : stimulus
        logic [31:0]       r;
        rv_isa_pkg::insn_t insn;
        rst_n           = 1'b0;
        trace_valid     = 1'b0;
        trace_insn      = '0;
        trace_pc_rdata  = '0;
        trace_pc_wdata  = '0;
        trace_rs1_rdata = '0;
        trace_rs2_rdata = '0;
        trace_rd_addr   = '0;
        trace_rd_wdata  = '0;
        trace_trap      = 1'b0;

        repeat (RESET_CYCLES) send(1'b1, make_insn(0), 1'b0, 3'b000, 1'b1);   // Dropped

        send(1'b1, make_insn(0), 1'b0, 3'b000, 1'b0);   // Correct, then mismatch right after
        send(1'b1, make_insn(1), 1'b0, 3'b010, 1'b0);
        insn = make_insn(1);
        insn[11:7] = 5'd0;
        send(1'b1, insn, 1'b0, 3'b010, 1'b0);           // Nonzero write to x0
        send(1'b1, make_insn(3), 1'b0, 3'b000, 1'b0);
        send(1'b1, make_insn(2), 1'b0, 3'b111, 1'b0);   // rd_addr wins
        send(1'b1, make_insn(0), 1'b1, 3'b011, 1'b0);
        send(1'b1, make_insn(4), 1'b0, 3'b010, 1'b0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = next_rand();
            send(r[19:16] != 4'd0, make_insn(kind_map[r[2:0]]), r[15:12] == 4'd0,
                 r[8] ? r[6:4] : 3'b000, 1'b0);
        end

        repeat (4) send(1'b0, '0, 1'b0, 3'b000, 1'b0);
        repeat (2) @(posedge clock);

        $display("Traces sent: %0d, errors: %0d", sent, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
common/rv_isa_pkg.sv
common/check_pkg.sv
common/retire_if.sv
verilog/retire_capture.sv
isa_spec/isa_spec_rv32i_alu.sv
verilog/retire_checker.sv
verilog/rvfi_check_top.sv
verification/rvfi_check_props.sv
verification/rvfi_check_tb.sv

/* Bender.yml */
package:
  name: rvfi_check

sources:
  - common/rv_isa_pkg.sv
  - common/check_pkg.sv
  - common/retire_if.sv
  - verilog/retire_capture.sv
  - isa_spec/isa_spec_rv32i_alu.sv
  - verilog/retire_checker.sv
  - verilog/rvfi_check_top.sv
  - target: simulation
    files:
      - verification/rvfi_check_props.sv
      - verification/rvfi_check_tb.sv
